// ==== common/id_pkg.sv ====
package id_pkg;

    // field widths
    localparam int XLEN = 32;
    localparam int OPC_W = 6;
    localparam int FN_W = 6;
    localparam int RA_W = 5;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [RA_W-1:0] reg_addr_t;
    typedef logic [OPC_W-1:0] opcode_t;
    typedef logic [FN_W-1:0] funct_t;

    // one-hot control vectors, bit order as execute expects
    typedef logic [11:0] alu_op_t;
    typedef logic [2:0] src1_sel_t;
    typedef logic [3:0] src2_sel_t;
    typedef logic [4:0] load_kind_t;
    typedef logic [2:0] store_kind_t;

    // alu ops, add in the top bit down to lui
    localparam alu_op_t ALU_ADD = 12'b1000_0000_0000;
    localparam alu_op_t ALU_SUB = 12'b0100_0000_0000;
    localparam alu_op_t ALU_SLT = 12'b0010_0000_0000;
    localparam alu_op_t ALU_SLTU = 12'b0001_0000_0000;
    localparam alu_op_t ALU_AND = 12'b0000_1000_0000;
    localparam alu_op_t ALU_NOR = 12'b0000_0100_0000;
    localparam alu_op_t ALU_OR = 12'b0000_0010_0000;
    localparam alu_op_t ALU_XOR = 12'b0000_0001_0000;
    localparam alu_op_t ALU_SLL = 12'b0000_0000_1000;
    localparam alu_op_t ALU_SRL = 12'b0000_0000_0100;
    localparam alu_op_t ALU_SRA = 12'b0000_0000_0010;
    localparam alu_op_t ALU_LUI = 12'b0000_0000_0001;

    // operand selects
    localparam src1_sel_t SRC1_RS = 3'b001;
    localparam src1_sel_t SRC1_PC = 3'b010;
    localparam src1_sel_t SRC1_SA = 3'b100;
    localparam src2_sel_t SRC2_RT = 4'b0001;
    localparam src2_sel_t SRC2_SIMM = 4'b0010;
    localparam src2_sel_t SRC2_EIGHT = 4'b0100;
    localparam src2_sel_t SRC2_ZIMM = 4'b1000;

    // load kinds {lb, lbu, lh, lhu, lw}, store kinds {sb, sh, sw}
    localparam load_kind_t LD_LB = 5'b10000;
    localparam load_kind_t LD_LBU = 5'b01000;
    localparam load_kind_t LD_LH = 5'b00100;
    localparam load_kind_t LD_LHU = 5'b00010;
    localparam load_kind_t LD_LW = 5'b00001;
    localparam store_kind_t ST_SB = 3'b100;
    localparam store_kind_t ST_SH = 3'b010;
    localparam store_kind_t ST_SW = 3'b001;

    // primary opcodes
    localparam opcode_t OPC_SPECIAL = 6'h00;
    localparam opcode_t OPC_REGIMM = 6'h01;
    localparam opcode_t OPC_J = 6'h02;
    localparam opcode_t OPC_JAL = 6'h03;
    localparam opcode_t OPC_BEQ = 6'h04;
    localparam opcode_t OPC_BNE = 6'h05;
    localparam opcode_t OPC_BLEZ = 6'h06;
    localparam opcode_t OPC_BGTZ = 6'h07;
    localparam opcode_t OPC_ADDI = 6'h08;
    localparam opcode_t OPC_ADDIU = 6'h09;
    localparam opcode_t OPC_SLTI = 6'h0a;
    localparam opcode_t OPC_SLTIU = 6'h0b;
    localparam opcode_t OPC_ANDI = 6'h0c;
    localparam opcode_t OPC_ORI = 6'h0d;
    localparam opcode_t OPC_XORI = 6'h0e;
    localparam opcode_t OPC_LUI = 6'h0f;
    localparam opcode_t OPC_LB = 6'h20;
    localparam opcode_t OPC_LH = 6'h21;
    localparam opcode_t OPC_LW = 6'h23;
    localparam opcode_t OPC_LBU = 6'h24;
    localparam opcode_t OPC_LHU = 6'h25;
    localparam opcode_t OPC_SB = 6'h28;
    localparam opcode_t OPC_SH = 6'h29;
    localparam opcode_t OPC_SW = 6'h2b;

    // special function codes
    localparam funct_t FN_SLL = 6'h00;
    localparam funct_t FN_SRL = 6'h02;
    localparam funct_t FN_SRA = 6'h03;
    localparam funct_t FN_SLLV = 6'h04;
    localparam funct_t FN_SRLV = 6'h06;
    localparam funct_t FN_SRAV = 6'h07;
    localparam funct_t FN_JR = 6'h08;
    localparam funct_t FN_JALR = 6'h09;
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR = 6'h25;
    localparam funct_t FN_XOR = 6'h26;
    localparam funct_t FN_NOR = 6'h27;
    localparam funct_t FN_SLT = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;

    // regimm branches are told apart by the rt field
    localparam reg_addr_t RT_BLTZ = 5'h00;
    localparam reg_addr_t RT_BGEZ = 5'h01;
    localparam reg_addr_t RT_BLTZAL = 5'h10;
    localparam reg_addr_t RT_BGEZAL = 5'h11;

    localparam reg_addr_t REG_LINK = 5'd31;
    // return address is pc + 8, past the delay slot
    localparam int LINK_OFFSET = 8;

    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_GEZ, BR_GTZ, BR_LEZ, BR_LTZ,
        BR_GEZAL, BR_LTZAL, BR_J, BR_JAL, BR_JR, BR_JALR
    } br_kind_t;

    typedef enum logic {
        BUF_EMPTY,
        BUF_HELD
    } buf_state_t;

    typedef struct packed {
        logic valid;
        word_t pc;
    } fetch_t;

    typedef struct packed {
        logic we;
        reg_addr_t waddr;
        word_t wdata;
    } rf_write_t;

    typedef struct packed {
        alu_op_t alu_op;
        src1_sel_t src1_sel;
        src2_sel_t src2_sel;
        logic ram_en;
        logic [3:0] ram_wen;
        logic rf_we;
        reg_addr_t rf_waddr;
        logic rf_from_load;
        load_kind_t load_kind;
        store_kind_t store_kind;
    } ex_ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
        ex_ctrl_t ctrl;
        word_t opnd1;
        word_t opnd2;
    } id_ex_t;

    typedef struct packed {
        logic taken;
        word_t target;
    } redirect_t;

endpackage

// ==== hw/if_id_latch.sv ====
module if_id_latch (
    input logic clk,
    input logic rst,
    input logic stall_id,
    input logic stall_ex,
    input id_pkg::fetch_t fetch,
    input id_pkg::word_t inst_rdata,
    output id_pkg::word_t pc,
    output id_pkg::word_t inst
);
    import id_pkg::*;

    fetch_t fetch_r;
    buf_state_t buf_state;
    word_t buf_inst;
    logic capture;

    // first cycle of a full stall, ram data still belongs to this item
    assign capture = stall_id && stall_ex && (buf_state == BUF_EMPTY);

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_r <= '0;
            buf_state <= BUF_EMPTY;
        end else if (!stall_id) begin
            fetch_r <= fetch;
            buf_state <= BUF_EMPTY;
        end else if (!stall_ex) begin
            // decode stalled but execute moves on, send a bubble
            fetch_r <= '0;
            buf_state <= BUF_EMPTY;
        end else if (capture) begin
            buf_state <= BUF_HELD;
        end
    end

    // buffered word, only meaningful while held
    always_ff @(posedge clk) begin
        if (capture) begin
            buf_inst <= inst_rdata;
        end
    end

    assign pc = fetch_r.pc;
    // invalid slot decodes as the zero word
    assign inst = !fetch_r.valid ? '0 :
                  (buf_state == BUF_HELD) ? buf_inst : inst_rdata;

    // a full stall keeps the same item in decode, whatever the ram returns
    a_hold_keeps_item: assert property (
        @(posedge clk) disable iff (rst)
        stall_id && stall_ex |=> $stable(pc) && $stable(inst)
    ) else $error("decoded item changed during a full stall");

endmodule

// ==== decode/inst_decoder.sv ====
module inst_decoder (
    input id_pkg::word_t inst,
    output id_pkg::ex_ctrl_t ctrl,
    output id_pkg::br_kind_t br_kind
);
    import id_pkg::*;

    opcode_t opcode;
    funct_t funct;
    reg_addr_t rt;
    reg_addr_t rd;

    assign opcode = inst[31:26];
    assign rt = inst[20:16];
    assign rd = inst[15:11];
    assign funct = inst[5:0];

    // plain alu result written to a register
    function automatic ex_ctrl_t alu_ctrl(alu_op_t op, src1_sel_t s1, src2_sel_t s2,
                                          reg_addr_t dst);
        ex_ctrl_t c;
        c = '0;
        c.alu_op = op;
        c.src1_sel = s1;
        c.src2_sel = s2;
        c.rf_we = 1'b1;
        c.rf_waddr = dst;
        return c;
    endfunction

    // address is rs + simm for every memory access
    function automatic ex_ctrl_t mem_ctrl(load_kind_t ld, store_kind_t st, reg_addr_t dst);
        ex_ctrl_t c;
        c = alu_ctrl(ALU_ADD, SRC1_RS, SRC2_SIMM, dst);
        c.ram_en = 1'b1;
        c.ram_wen = {4{|st}};
        c.rf_we = |ld;
        c.rf_from_load = |ld;
        c.load_kind = ld;
        c.store_kind = st;
        return c;
    endfunction

    // link kinds compute pc + 8 in the alu
    function automatic ex_ctrl_t link_ctrl(reg_addr_t dst);
        return alu_ctrl(ALU_ADD, SRC1_PC, SRC2_EIGHT, dst);
    endfunction

    always_comb begin
        ctrl = '0;
        br_kind = BR_NONE;
        case (opcode)
            OPC_SPECIAL: begin
                case (funct)
                    FN_ADD, FN_ADDU: ctrl = alu_ctrl(ALU_ADD, SRC1_RS, SRC2_RT, rd);
                    FN_SUB, FN_SUBU: ctrl = alu_ctrl(ALU_SUB, SRC1_RS, SRC2_RT, rd);
                    FN_SLT: ctrl = alu_ctrl(ALU_SLT, SRC1_RS, SRC2_RT, rd);
                    FN_SLTU: ctrl = alu_ctrl(ALU_SLTU, SRC1_RS, SRC2_RT, rd);
                    FN_AND: ctrl = alu_ctrl(ALU_AND, SRC1_RS, SRC2_RT, rd);
                    FN_OR: ctrl = alu_ctrl(ALU_OR, SRC1_RS, SRC2_RT, rd);
                    FN_XOR: ctrl = alu_ctrl(ALU_XOR, SRC1_RS, SRC2_RT, rd);
                    FN_NOR: ctrl = alu_ctrl(ALU_NOR, SRC1_RS, SRC2_RT, rd);
                    // variable shifts take the amount from rs
                    FN_SLLV: ctrl = alu_ctrl(ALU_SLL, SRC1_RS, SRC2_RT, rd);
                    FN_SRLV: ctrl = alu_ctrl(ALU_SRL, SRC1_RS, SRC2_RT, rd);
                    FN_SRAV: ctrl = alu_ctrl(ALU_SRA, SRC1_RS, SRC2_RT, rd);
                    FN_SLL: begin
                        // the zero word is the nop and also the empty slot
                        if (inst != '0) begin
                            ctrl = alu_ctrl(ALU_SLL, SRC1_SA, SRC2_RT, rd);
                        end
                    end
                    FN_SRL: ctrl = alu_ctrl(ALU_SRL, SRC1_SA, SRC2_RT, rd);
                    FN_SRA: ctrl = alu_ctrl(ALU_SRA, SRC1_SA, SRC2_RT, rd);
                    FN_JR: br_kind = BR_JR;
                    FN_JALR: begin
                        ctrl = link_ctrl(rd);
                        br_kind = BR_JALR;
                    end
                    default: ;
                endcase
            end
            OPC_REGIMM: begin
                case (rt)
                    RT_BLTZ: br_kind = BR_LTZ;
                    RT_BGEZ: br_kind = BR_GEZ;
                    // link written whether taken or not
                    RT_BLTZAL: begin
                        ctrl = link_ctrl(REG_LINK);
                        br_kind = BR_LTZAL;
                    end
                    RT_BGEZAL: begin
                        ctrl = link_ctrl(REG_LINK);
                        br_kind = BR_GEZAL;
                    end
                    default: ;
                endcase
            end
            OPC_J: br_kind = BR_J;
            OPC_JAL: begin
                ctrl = link_ctrl(REG_LINK);
                br_kind = BR_JAL;
            end
            OPC_BEQ: br_kind = BR_EQ;
            OPC_BNE: br_kind = BR_NE;
            OPC_BLEZ: br_kind = BR_LEZ;
            OPC_BGTZ: br_kind = BR_GTZ;
            OPC_ADDI, OPC_ADDIU: ctrl = alu_ctrl(ALU_ADD, SRC1_RS, SRC2_SIMM, rt);
            OPC_SLTI: ctrl = alu_ctrl(ALU_SLT, SRC1_RS, SRC2_SIMM, rt);
            OPC_SLTIU: ctrl = alu_ctrl(ALU_SLTU, SRC1_RS, SRC2_SIMM, rt);
            // logic immediates are zero extended
            OPC_ANDI: ctrl = alu_ctrl(ALU_AND, SRC1_RS, SRC2_ZIMM, rt);
            OPC_ORI: ctrl = alu_ctrl(ALU_OR, SRC1_RS, SRC2_ZIMM, rt);
            OPC_XORI: ctrl = alu_ctrl(ALU_XOR, SRC1_RS, SRC2_ZIMM, rt);
            // lui needs no first operand
            OPC_LUI: ctrl = alu_ctrl(ALU_LUI, '0, SRC2_SIMM, rt);
            OPC_LB: ctrl = mem_ctrl(LD_LB, '0, rt);
            OPC_LBU: ctrl = mem_ctrl(LD_LBU, '0, rt);
            OPC_LH: ctrl = mem_ctrl(LD_LH, '0, rt);
            OPC_LHU: ctrl = mem_ctrl(LD_LHU, '0, rt);
            OPC_LW: ctrl = mem_ctrl(LD_LW, '0, rt);
            OPC_SB: ctrl = mem_ctrl('0, ST_SB, '0);
            OPC_SH: ctrl = mem_ctrl('0, ST_SH, '0);
            OPC_SW: ctrl = mem_ctrl('0, ST_SW, '0);
            default: ;
        endcase
    end

endmodule

// ==== operand/reg_file.sv ====
module reg_file (
    input logic clk,
    input id_pkg::reg_addr_t raddr1,
    input id_pkg::reg_addr_t raddr2,
    input id_pkg::rf_write_t wr,
    output id_pkg::word_t rdata1,
    output id_pkg::word_t rdata2
);
    import id_pkg::*;

    word_t regs [32];

    // register 0 is never written
    always_ff @(posedge clk) begin
        if (wr.we && (wr.waddr != '0)) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // asynchronous reads, r0 forced to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== operand/operand_fwd.sv ====
module operand_fwd (
    input id_pkg::word_t inst,
    input id_pkg::word_t rdata1,
    input id_pkg::word_t rdata2,
    input id_pkg::rf_write_t ex_wr,
    input id_pkg::rf_write_t mem_wr,
    input id_pkg::rf_write_t wb_wr,
    input logic ex_is_load,
    output id_pkg::reg_addr_t raddr1,
    output id_pkg::reg_addr_t raddr2,
    output id_pkg::word_t opnd1,
    output id_pkg::word_t opnd2,
    output logic stall_req
);
    import id_pkg::*;

    reg_addr_t rs;
    reg_addr_t rt;

    assign rs = inst[25:21];
    assign rt = inst[20:16];
    assign raddr1 = rs;
    assign raddr2 = rt;

    // writes to r0 never forward
    function automatic logic hits(rf_write_t wr, reg_addr_t addr);
        return wr.we && (wr.waddr == addr) && (addr != '0);
    endfunction

    // youngest result wins: ex, then mem, then wb
    function automatic word_t pick(reg_addr_t addr, word_t rf_data, rf_write_t e,
                                   rf_write_t m, rf_write_t w);
        if (hits(e, addr)) begin
            return e.wdata;
        end
        if (hits(m, addr)) begin
            return m.wdata;
        end
        if (hits(w, addr)) begin
            return w.wdata;
        end
        return rf_data;
    endfunction

    assign opnd1 = pick(rs, rdata1, ex_wr, mem_wr, wb_wr);
    assign opnd2 = pick(rt, rdata2, ex_wr, mem_wr, wb_wr);

    // load data not ready until mem, so hold decode one cycle
    assign stall_req = ex_is_load && (hits(ex_wr, rs) || hits(ex_wr, rt));

endmodule

// ==== hw/branch_unit.sv ====
module branch_unit (
    input id_pkg::word_t pc,
    input id_pkg::word_t inst,
    input id_pkg::br_kind_t br_kind,
    input id_pkg::word_t opnd1,
    input id_pkg::word_t opnd2,
    output id_pkg::redirect_t redirect
);
    import id_pkg::*;

    word_t pc_plus_4;
    word_t br_target;
    word_t jmp_target;
    word_t target;
    logic taken;
    logic rs_neg;
    logic rs_zero;

    assign pc_plus_4 = pc + 32'd4;
    // offset counts words, relative to the delay slot
    assign br_target = pc_plus_4 + {{14{inst[15]}}, inst[15:0], 2'b00};
    // region of the delay slot plus the 26 bit index
    assign jmp_target = {pc_plus_4[31:28], inst[25:0], 2'b00};

    assign rs_neg = opnd1[31];
    assign rs_zero = (opnd1 == '0);

    always_comb begin
        taken = 1'b0;
        target = br_target;
        case (br_kind)
            BR_EQ: taken = (opnd1 == opnd2);
            BR_NE: taken = (opnd1 != opnd2);
            BR_GEZ, BR_GEZAL: taken = !rs_neg;
            BR_GTZ: taken = !rs_neg && !rs_zero;
            BR_LEZ: taken = rs_neg || rs_zero;
            BR_LTZ, BR_LTZAL: taken = rs_neg;
            // unconditional kinds
            BR_J, BR_JAL: begin
                taken = 1'b1;
                target = jmp_target;
            end
            BR_JR, BR_JALR: begin
                taken = 1'b1;
                target = opnd1;
            end
            default: ;
        endcase
    end

    // target only meaningful when taken
    assign redirect = '{taken: taken, target: taken ? target : word_t'(0)};

endmodule

// ==== hw/id_stage.sv ====
module id_stage (
    input logic clk,
    input logic rst,
    input logic stall_id,
    input logic stall_ex,
    input logic ex_is_load,
    input id_pkg::fetch_t fetch,
    input id_pkg::word_t inst_rdata,
    input id_pkg::rf_write_t ex_wr,
    input id_pkg::rf_write_t mem_wr,
    input id_pkg::rf_write_t wb_wr,
    output id_pkg::id_ex_t id_ex,
    output id_pkg::redirect_t redirect,
    output logic stall_req
);
    import id_pkg::*;

    // latched item
    word_t pc;
    word_t inst;

    // decode results
    ex_ctrl_t ctrl;
    br_kind_t br_kind;

    // operand path
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    word_t rdata1;
    word_t rdata2;
    word_t opnd1;
    word_t opnd2;

    if_id_latch u_latch (
        .clk        (clk),
        .rst        (rst),
        .stall_id   (stall_id),
        .stall_ex   (stall_ex),
        .fetch      (fetch),
        .inst_rdata (inst_rdata),
        .pc         (pc),
        .inst       (inst)
    );

    inst_decoder u_decoder (
        .inst    (inst),
        .ctrl    (ctrl),
        .br_kind (br_kind)
    );

    // writeback result lands here, earlier stages only forward
    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .wr     (wb_wr),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    operand_fwd u_operand_fwd (
        .inst       (inst),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .ex_wr      (ex_wr),
        .mem_wr     (mem_wr),
        .wb_wr      (wb_wr),
        .ex_is_load (ex_is_load),
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .opnd1      (opnd1),
        .opnd2      (opnd2),
        .stall_req  (stall_req)
    );

    // branch condition uses forwarded operands
    branch_unit u_branch_unit (
        .pc       (pc),
        .inst     (inst),
        .br_kind  (br_kind),
        .opnd1    (opnd1),
        .opnd2    (opnd2),
        .redirect (redirect)
    );

    assign id_ex = '{pc: pc, inst: inst, ctrl: ctrl, opnd1: opnd1, opnd2: opnd2};

endmodule

// ==== sim/id_model.svh ====
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

// mirror of the fetch latch and instruction buffer
logic m_valid = 1'b0;
word_t m_pc = '0;
logic m_held = 1'b0;
word_t m_buf = '0;
// mirror of the general registers, filled by the preload phase
word_t m_regs [32];

// word seen by decode this cycle
function automatic word_t model_inst(word_t rdata);
    if (!m_valid) begin
        return '0;
    end
    return m_held ? m_buf : rdata;
endfunction

// expected execute controls for one instruction word
function automatic ex_ctrl_t exp_ctrl(word_t inst);
    ex_ctrl_t c;
    opcode_t op;
    funct_t fn;
    reg_addr_t rt;
    logic is_load;
    logic is_store;
    c = '0;
    op = inst[31:26];
    fn = inst[5:0];
    rt = inst[20:16];
    if (op == OPC_SPECIAL && inst != '0) begin
        case (fn)
            FN_ADD, FN_ADDU: c.alu_op = ALU_ADD;
            FN_SUB, FN_SUBU: c.alu_op = ALU_SUB;
            FN_SLT: c.alu_op = ALU_SLT;
            FN_SLTU: c.alu_op = ALU_SLTU;
            FN_AND: c.alu_op = ALU_AND;
            FN_OR: c.alu_op = ALU_OR;
            FN_XOR: c.alu_op = ALU_XOR;
            FN_NOR: c.alu_op = ALU_NOR;
            FN_SLL, FN_SLLV: c.alu_op = ALU_SLL;
            FN_SRL, FN_SRLV: c.alu_op = ALU_SRL;
            FN_SRA, FN_SRAV: c.alu_op = ALU_SRA;
            default: ;
        endcase
        // constant shifts sit at funct 0 to 3
        c.src1_sel = (fn[5:2] == 4'h0) ? SRC1_SA : SRC1_RS;
        c.src2_sel = SRC2_RT;
        c.rf_waddr = inst[15:11];
    end else if (op >= OPC_ADDI && op <= OPC_LUI) begin
        case (op)
            OPC_ADDI, OPC_ADDIU: c.alu_op = ALU_ADD;
            OPC_SLTI: c.alu_op = ALU_SLT;
            OPC_SLTIU: c.alu_op = ALU_SLTU;
            OPC_ANDI: c.alu_op = ALU_AND;
            OPC_ORI: c.alu_op = ALU_OR;
            OPC_XORI: c.alu_op = ALU_XOR;
            default: c.alu_op = ALU_LUI;
        endcase
        c.src1_sel = (op == OPC_LUI) ? '0 : SRC1_RS;
        // logic immediates zero extended
        c.src2_sel = (op == OPC_ANDI || op == OPC_ORI || op == OPC_XORI) ? SRC2_ZIMM
                                                                         : SRC2_SIMM;
        c.rf_waddr = rt;
    end
    if (c.alu_op == '0) begin
        c = '0;
    end else begin
        c.rf_we = 1'b1;
    end
    // memory access, address rs + simm
    case (op)
        OPC_LB: c.load_kind = LD_LB;
        OPC_LBU: c.load_kind = LD_LBU;
        OPC_LH: c.load_kind = LD_LH;
        OPC_LHU: c.load_kind = LD_LHU;
        OPC_LW: c.load_kind = LD_LW;
        OPC_SB: c.store_kind = ST_SB;
        OPC_SH: c.store_kind = ST_SH;
        OPC_SW: c.store_kind = ST_SW;
        default: ;
    endcase
    is_load = (c.load_kind != '0);
    is_store = (c.store_kind != '0);
    if (is_load || is_store) begin
        c.alu_op = ALU_ADD;
        c.src1_sel = SRC1_RS;
        c.src2_sel = SRC2_SIMM;
        c.ram_en = 1'b1;
        c.ram_wen = is_store ? 4'hf : 4'h0;
        c.rf_we = is_load;
        c.rf_from_load = is_load;
        c.rf_waddr = is_load ? rt : '0;
    end
    // link kinds write pc + 8
    if (op == OPC_JAL || (op == OPC_REGIMM && (rt == RT_BLTZAL || rt == RT_BGEZAL)) ||
        (op == OPC_SPECIAL && fn == FN_JALR)) begin
        c = '0;
        c.alu_op = ALU_ADD;
        c.src1_sel = SRC1_PC;
        c.src2_sel = SRC2_EIGHT;
        c.rf_we = 1'b1;
        c.rf_waddr = (op == OPC_SPECIAL) ? inst[15:11] : REG_LINK;
    end
    return c;
endfunction

// forwarding priority ex, mem, wb, then registers
function automatic word_t exp_opnd(reg_addr_t a, rf_write_t e, rf_write_t m, rf_write_t w);
    if (a == '0) begin
        return '0;
    end
    if (e.we && e.waddr == a) begin
        return e.wdata;
    end
    if (m.we && m.waddr == a) begin
        return m.wdata;
    end
    if (w.we && w.waddr == a) begin
        return w.wdata;
    end
    return m_regs[a];
endfunction

function automatic logic exp_stall(word_t inst, rf_write_t e, logic is_load);
    return is_load && e.we && e.waddr != '0 &&
           (e.waddr == inst[25:21] || e.waddr == inst[20:16]);
endfunction

function automatic redirect_t exp_redirect(word_t pc, word_t inst, word_t o1, word_t o2);
    redirect_t r;
    word_t pc4;
    reg_addr_t rt;
    r = '0;
    pc4 = pc + 32'd4;
    rt = inst[20:16];
    r.target = pc4 + ({{16{inst[15]}}, inst[15:0]} << 2);
    case (inst[31:26])
        OPC_BEQ: r.taken = (o1 == o2);
        OPC_BNE: r.taken = (o1 != o2);
        OPC_BLEZ: r.taken = ($signed(o1) <= 0);
        OPC_BGTZ: r.taken = ($signed(o1) > 0);
        OPC_REGIMM: begin
            if (rt == RT_BLTZ || rt == RT_BLTZAL) begin
                r.taken = ($signed(o1) < 0);
            end
            if (rt == RT_BGEZ || rt == RT_BGEZAL) begin
                r.taken = ($signed(o1) >= 0);
            end
        end
        OPC_J, OPC_JAL: begin
            r.taken = 1'b1;
            r.target = {pc4[31:28], inst[25:0], 2'b00};
        end
        OPC_SPECIAL: begin
            if (inst[5:0] == FN_JR || inst[5:0] == FN_JALR) begin
                r.taken = 1'b1;
                r.target = o1;
            end
        end
        default: ;
    endcase
    if (!r.taken) begin
        r.target = '0;
    end
    return r;
endfunction

// state update at the rising edge, same stall rule as the stage
task automatic model_clock(logic r, logic s_id, logic s_ex, fetch_t f, word_t rdata,
                           rf_write_t w);
    if (w.we && w.waddr != '0) begin
        m_regs[w.waddr] = w.wdata;
    end
    if (r) begin
        m_valid = 1'b0;
        m_pc = '0;
        m_held = 1'b0;
    end else if (!s_id) begin
        m_valid = f.valid;
        m_pc = f.pc;
        m_held = 1'b0;
    end else if (!s_ex) begin
        m_valid = 1'b0;
        m_pc = '0;
        m_held = 1'b0;
    end else if (!m_held) begin
        m_held = 1'b1;
        m_buf = rdata;
    end
endtask

`endif

// ==== sim/tb_id_stage.sv ====
module tb_id_stage;
    import id_pkg::*;

    localparam int SEED = 39400;
    localparam int RST_TIMEOUT = 50;
    localparam int NUM_ITEMS = 3000;
    localparam int RUN_TIMEOUT = 30000;

    logic clk = 1'b0;
    logic rst;
    logic stall_id;
    logic stall_ex;
    logic ex_is_load;
    fetch_t fetch;
    word_t inst_rdata;
    rf_write_t ex_wr;
    rf_write_t mem_wr;
    rf_write_t wb_wr;
    id_ex_t id_ex;
    redirect_t redirect;
    logic stall_req;

    int checks = 0;
    int errors = 0;

    // kept encodings for random instructions
    funct_t fn_list [18] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR,
                             FN_NOR, FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV,
                             FN_SRLV, FN_SRAV, FN_JR, FN_JALR};
    opcode_t op_list [22] = '{OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU, OPC_ANDI, OPC_ORI,
                              OPC_XORI, OPC_LUI, OPC_LB, OPC_LH, OPC_LW, OPC_LBU, OPC_LHU,
                              OPC_SB, OPC_SH, OPC_SW, OPC_J, OPC_JAL, OPC_BEQ, OPC_BNE,
                              OPC_BLEZ, OPC_BGTZ};
    reg_addr_t rimm_list [4] = '{RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL};

    `include "id_model.svh"

    id_stage u_dut (
        .clk        (clk),
        .rst        (rst),
        .stall_id   (stall_id),
        .stall_ex   (stall_ex),
        .ex_is_load (ex_is_load),
        .fetch      (fetch),
        .inst_rdata (inst_rdata),
        .ex_wr      (ex_wr),
        .mem_wr     (mem_wr),
        .wb_wr      (wb_wr),
        .id_ex      (id_ex),
        .redirect   (redirect),
        .stall_req  (stall_req)
    );

    always #5 clk = ~clk;

    // reset for 8 cycles, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic word_t gen_inst();
        word_t w;
        w = $urandom();
        // small indices so forwarding hits often
        w[25:21] = 5'($urandom_range(0, 7));
        w[20:16] = 5'($urandom_range(0, 7));
        case ($urandom_range(0, 9))
            0, 1, 2: begin
                w[31:26] = OPC_SPECIAL;
                w[5:0] = fn_list[$urandom_range(0, 17)];
            end
            3: begin
                w[31:26] = OPC_REGIMM;
                w[20:16] = rimm_list[$urandom_range(0, 3)];
            end
            // opcodes 0x10-0x1f and 0x30-0x3f are not decoded
            8: w[31:26] = {($urandom_range(0, 1) != 0) ? 2'b01 : 2'b11, 4'($urandom())};
            9: w = '0;
            default: w[31:26] = op_list[$urandom_range(0, 21)];
        endcase
        return w;
    endfunction

    function automatic rf_write_t rand_write();
        rf_write_t r;
        r.we = 1'($urandom_range(0, 1));
        r.waddr = 5'($urandom_range(0, 7));
        r.wdata = $urandom();
        return r;
    endfunction

    // no item, no result traffic, ram data still random
    task automatic drive_idle();
        stall_id = 1'b0;
        stall_ex = 1'b0;
        ex_is_load = 1'b0;
        fetch = '0;
        inst_rdata = $urandom();
        ex_wr = '0;
        mem_wr = '0;
        wb_wr = '0;
    endtask

    // full stall with a jal on the ram port and a load in ex hitting its rs
    task automatic drive_reset_phase();
        drive_idle();
        stall_id = 1'b1;
        stall_ex = 1'b1;
        ex_is_load = 1'b1;
        fetch.valid = 1'b1;
        fetch.pc = $urandom() & 32'hffff_fffc;
        ex_wr.we = 1'b1;
        ex_wr.waddr = 5'($urandom_range(1, 7));
        ex_wr.wdata = $urandom();
        inst_rdata = {OPC_JAL, ex_wr.waddr, 21'($urandom())};
    endtask

    task automatic drive_random();
        fetch.valid = ($urandom_range(0, 9) != 0);
        fetch.pc = $urandom() & 32'hffff_fffc;
        inst_rdata = gen_inst();
        stall_id = ($urandom_range(0, 2) == 0);
        stall_ex = 1'($urandom_range(0, 1));
        ex_wr = rand_write();
        mem_wr = rand_write();
        wb_wr = rand_write();
        ex_is_load = ex_wr.we && ($urandom_range(0, 2) == 0);
    endtask

    task automatic check_outputs();
        word_t cur;
        ex_ctrl_t ec;
        word_t o1;
        word_t o2;
        redirect_t er;
        cur = model_inst(inst_rdata);
        ec = exp_ctrl(cur);
        o1 = exp_opnd(cur[25:21], ex_wr, mem_wr, wb_wr);
        o2 = exp_opnd(cur[20:16], ex_wr, mem_wr, wb_wr);
        er = exp_redirect(m_pc, cur, o1, o2);
        compare("id_ex.pc", 64'(id_ex.pc), 64'(m_pc));
        compare("id_ex.inst", 64'(id_ex.inst), 64'(cur));
        compare("id_ex.ctrl.alu_op", 64'(id_ex.ctrl.alu_op), 64'(ec.alu_op));
        compare("id_ex.ctrl.src1_sel", 64'(id_ex.ctrl.src1_sel), 64'(ec.src1_sel));
        compare("id_ex.ctrl.src2_sel", 64'(id_ex.ctrl.src2_sel), 64'(ec.src2_sel));
        compare("id_ex.ctrl.ram_en", 64'(id_ex.ctrl.ram_en), 64'(ec.ram_en));
        compare("id_ex.ctrl.ram_wen", 64'(id_ex.ctrl.ram_wen), 64'(ec.ram_wen));
        compare("id_ex.ctrl.rf_we", 64'(id_ex.ctrl.rf_we), 64'(ec.rf_we));
        compare("id_ex.ctrl.rf_waddr", 64'(id_ex.ctrl.rf_waddr), 64'(ec.rf_waddr));
        compare("id_ex.ctrl.rf_from_load", 64'(id_ex.ctrl.rf_from_load), 64'(ec.rf_from_load));
        compare("id_ex.ctrl.load_kind", 64'(id_ex.ctrl.load_kind), 64'(ec.load_kind));
        compare("id_ex.ctrl.store_kind", 64'(id_ex.ctrl.store_kind), 64'(ec.store_kind));
        compare("id_ex.opnd1", 64'(id_ex.opnd1), 64'(o1));
        compare("id_ex.opnd2", 64'(id_ex.opnd2), 64'(o2));
        compare("redirect.taken", 64'(redirect.taken), 64'(er.taken));
        compare("redirect.target", 64'(redirect.target), 64'(er.target));
        compare("stall_req", 64'(stall_req), 64'(exp_stall(cur, ex_wr, ex_is_load)));
    endtask

    // one checked cycle, inputs already driven on the falling edge
    task automatic check_and_clock();
        #1;
        check_outputs();
        model_clock(rst, stall_id, stall_ex, fetch, inst_rdata, wb_wr);
    endtask

    initial begin
        int n;
        int items;
        void'($urandom(SEED));
        // stage held during reset, only reset can clear the latch
        drive_reset_phase();
        n = 0;
        while (rst !== 1'b0 && n < RST_TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (rst !== 1'b0) begin
            errors++;
            $display("reset was not released within %0d cycles", RST_TIMEOUT);
        end else begin
            // latch still as reset left it, nothing valid in decode
            compare("id_ex.ctrl", 64'(id_ex.ctrl), 64'd0);
            compare("redirect.taken", 64'(redirect.taken), 64'd0);
            compare("stall_req", 64'(stall_req), 64'd0);
            model_clock(rst, stall_id, stall_ex, fetch, inst_rdata, wb_wr);
            // fill every register through writeback, r0 write must be ignored
            for (int i = 0; i < 32; i++) begin
                @(negedge clk);
                drive_idle();
                wb_wr.we = 1'b1;
                wb_wr.waddr = 5'(i);
                wb_wr.wdata = $urandom();
                check_and_clock();
            end
            items = 0;
            n = 0;
            while (items < NUM_ITEMS && n < RUN_TIMEOUT) begin
                @(negedge clk);
                drive_random();
                // an item leaves decode when the latch advances
                if (m_valid && !stall_id) begin
                    items++;
                end
                check_and_clock();
                n++;
            end
            if (items < NUM_ITEMS) begin
                errors++;
                $display("only %0d of %0d items decoded within %0d cycles",
                         items, NUM_ITEMS, RUN_TIMEOUT);
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+sim
common/id_pkg.sv
hw/if_id_latch.sv
decode/inst_decoder.sv
operand/reg_file.sv
operand/operand_fwd.sv
hw/branch_unit.sv
hw/id_stage.sv
sim/tb_id_stage.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - files:
      - common/id_pkg.sv
      - hw/if_id_latch.sv
      - decode/inst_decoder.sv
      - operand/reg_file.sv
      - operand/operand_fwd.sv
      - hw/branch_unit.sv
      - hw/id_stage.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_id_stage.sv
